// File: flist.f
hw/rdma_flow_pkg.sv
hw/ssn_table.sv
hw/flow_sequencer.sv
hw/ack_queue.sv
hw/cc_queue.sv
hw/rdma_flow.sv
test/tb_rdma_flow.sv

// File: run_sim.sh
#!/bin/sh
# Builds the testbench with Verilator and runs it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal -f flist.f --top-module tb_rdma_flow -o tb_rdma_flow
status=$?
if [ $status -ne 0 ]; then
    echo "Verilator build failed with status $status"
    exit 1
fi

output=$(./obj_dir/tb_rdma_flow)
status=$?
printf '%s\n' "$output"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if printf '%s\n' "$output" | grep -qx "Test completed successfully"; then
    exit 0
fi
exit 1

// File: test/tb_rdma_flow.sv
`timescale 1ns/1ns

module tb_rdma_flow;

    // About 700 cycles of directed tests plus wide margin
    localparam int TIMEOUT_CYCLES = 4000;
    localparam logic [31:0] LFSR_SEED = 32'h3f1b_1b69;
    localparam logic [31:0] LFSR_TAPS = 32'h8020_0003;

    logic                   aclk = 1'b0;
    logic                   aresetn;
    logic                   s_req_valid;
    logic                   s_req_ready;
    rdma_flow_pkg::req_t    s_req_data;
    logic                   m_req_valid;
    logic                   m_req_ready;
    rdma_flow_pkg::req_t    m_req_data;
    logic                   s_ack_valid;
    logic                   s_ack_ready;
    rdma_flow_pkg::ack_in_t s_ack_data;
    logic                   m_ack_valid;
    logic                   m_ack_ready;
    rdma_flow_pkg::ack_t    m_ack_data;

    rdma_flow_pkg::req_t exp_req [$];
    rdma_flow_pkg::req_t got_req [$];
    rdma_flow_pkg::ack_t exp_ack [$];
    rdma_flow_pkg::ack_t got_ack [$];
    int got_req_cyc [$];

    // Window model with one slot count and head per key
    int out_m [2**rdma_flow_pkg::KEY_BITS];
    int head_m [2**rdma_flow_pkg::KEY_BITS];

    int cycle = 0;
    int errors = 0;
    int tests_run = 0;
    int tests_passed = 0;
    logic [1:0] ready_mode;
    logic [31:0] len_lfsr;
    logic [31:0] rdy_lfsr;

    rdma_flow dut (
        .aclk        (aclk),
        .aresetn     (aresetn),
        .s_req_valid (s_req_valid),
        .s_req_ready (s_req_ready),
        .s_req_data  (s_req_data),
        .m_req_valid (m_req_valid),
        .m_req_ready (m_req_ready),
        .m_req_data  (m_req_data),
        .s_ack_valid (s_ack_valid),
        .s_ack_ready (s_ack_ready),
        .s_ack_data  (s_ack_data),
        .m_ack_valid (m_ack_valid),
        .m_ack_ready (m_ack_ready),
        .m_ack_data  (m_ack_data)
    );

    always #2 aclk = ~aclk;

    always @(posedge aclk) begin
        cycle <= cycle + 1;
        if (cycle >= TIMEOUT_CYCLES) begin
            $display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("Test failed");
            $finish;
        end
    end

    // Mode 0 stalls, 1 always ready, 2 random stalls
    always @(posedge aclk) begin
        #1;
        if (ready_mode == 2'd2) begin
            rdy_lfsr = lfsr_next(rdy_lfsr);
            m_req_ready = rdy_lfsr[0];
        end else begin
            m_req_ready = ready_mode[0];
        end
    end

    always @(negedge aclk) begin
        if (aresetn && m_req_valid && m_req_ready) begin
            got_req.push_back(m_req_data);
            got_req_cyc.push_back(cycle);
        end
        if (aresetn && m_ack_valid && m_ack_ready) begin
            got_ack.push_back(m_ack_data);
        end
    end

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        lfsr_next = s[0] ? ((s >> 1) ^ LFSR_TAPS) : (s >> 1);
    endfunction

    task automatic take_bits(input int n, output logic [15:0] bits);
        bits = '0;
        for (int i = 0; i < n; i++) begin
            len_lfsr = lfsr_next(len_lfsr);
            bits = {bits[14:0], len_lfsr[0]};
        end
    endtask

    function automatic rdma_flow_pkg::key_t key_of(input logic rd, input rdma_flow_pkg::vfid_t vfid,
                                                   input rdma_flow_pkg::pid_t pid);
        key_of = {rd, vfid[rdma_flow_pkg::N_REGIONS_BITS-1:0], pid};
    endfunction

    task automatic compare_req(input string name, input rdma_flow_pkg::req_t exp,
                               input rdma_flow_pkg::req_t act);
        if (act !== exp) begin
            errors++;
            $display("MISMATCH %s: expected %h actual %h", name, exp, act);
        end
    endtask

    task automatic compare_ack(input string name, input rdma_flow_pkg::ack_t exp,
                               input rdma_flow_pkg::ack_t act);
        if (act !== exp) begin
            errors++;
            $display("MISMATCH %s: expected %h actual %h", name, exp, act);
        end
    endtask

    task automatic compare_bit(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            errors++;
            $display("MISMATCH %s: expected %b actual %b", name, exp, act);
        end
    endtask

    task automatic set_ready_mode(input logic [1:0] mode);
        @(negedge aclk);
        ready_mode = mode;
    endtask

    task automatic make_req(input rdma_flow_pkg::opcode_t op, input rdma_flow_pkg::vfid_t vfid,
                            input rdma_flow_pkg::pid_t pid, output rdma_flow_pkg::req_t r);
        logic [15:0] len;
        take_bits(16, len);
        r.opcode = op;
        r.vfid = vfid;
        r.pid = pid;
        // Source offs is arbitrary since the DUT overwrites it
        r.offs = len[15:14];
        r.len = len;
    endtask

    task automatic make_ack(input rdma_flow_pkg::opcode_t op, input rdma_flow_pkg::vfid_t vfid,
                            input rdma_flow_pkg::pid_t pid, input logic [1:0] ecn,
                            input logic last, output rdma_flow_pkg::ack_in_t a);
        a.ack.opcode = op;
        a.ack.vfid = vfid;
        a.ack.pid = pid;
        a.ack.ecn = ecn;
        a.last = last;
    endtask

    task automatic start_req(input rdma_flow_pkg::req_t r);
        @(posedge aclk);
        #1;
        s_req_valid = 1'b1;
        s_req_data = r;
    endtask

    task automatic finish_req(input string name);
        rdma_flow_pkg::key_t k;
        rdma_flow_pkg::req_t exp;
        k = key_of(s_req_data.opcode == rdma_flow_pkg::OP_RD_REQ, s_req_data.vfid, s_req_data.pid);
        @(negedge aclk);
        while (!s_req_ready) @(negedge aclk);
        @(posedge aclk);
        #1;
        s_req_valid = 1'b0;
        if (out_m[k] >= rdma_flow_pkg::RDMA_N_OST) begin
            errors++;
            $display("%s: a request was accepted while its window was full", name);
        end
        exp = s_req_data;
        exp.offs = rdma_flow_pkg::ost_t'(head_m[k]);
        exp_req.push_back(exp);
        head_m[k] = (head_m[k] + 1) % rdma_flow_pkg::RDMA_N_OST;
        out_m[k]++;
    endtask

    task automatic send_req(input string name, input rdma_flow_pkg::req_t r);
        start_req(r);
        finish_req(name);
    endtask

    task automatic expect_blocked(input string name, input int n);
        repeat (n) begin
            @(negedge aclk);
            if (s_req_ready) begin
                errors++;
                $display("%s: a request was accepted although its window was full", name);
            end
        end
    endtask

    task automatic send_ack(input string name, input rdma_flow_pkg::ack_in_t a);
        rdma_flow_pkg::key_t k;
        k = key_of(a.ack.opcode == rdma_flow_pkg::OP_RD_RESP, a.ack.vfid, a.ack.pid);
        @(posedge aclk);
        #1;
        s_ack_valid = 1'b1;
        s_ack_data = a;
        @(negedge aclk);
        while (!s_ack_ready) @(negedge aclk);
        @(posedge aclk);
        #1;
        s_ack_valid = 1'b0;
        if (out_m[k] > 0) begin
            out_m[k]--;
        end
        if (a.last) begin
            exp_ack.push_back(a.ack);
        end
    endtask

    task automatic wait_outputs(input string name);
        while (got_req.size() < exp_req.size() || got_ack.size() < exp_ack.size()) begin
            @(posedge aclk);
        end
        repeat (4) @(posedge aclk);
        if (got_req.size() != exp_req.size() || got_ack.size() != exp_ack.size()) begin
            errors++;
            $display("%s: more outputs appeared than were expected", name);
        end
        while (exp_req.size() > 0 && got_req.size() > 0) begin
            compare_req(name, exp_req.pop_front(), got_req.pop_front());
        end
        while (exp_ack.size() > 0 && got_ack.size() > 0) begin
            compare_ack(name, exp_ack.pop_front(), got_ack.pop_front());
        end
        got_req.delete();
        got_ack.delete();
        got_req_cyc.delete();
    endtask

    task automatic check_spacing(input string name, input int min_d, input int max_d);
        int d;
        while (got_req_cyc.size() < 4) @(posedge aclk);
        for (int i = 1; i < 4; i++) begin
            d = got_req_cyc[i] - got_req_cyc[i-1];
            if (d < min_d || d > max_d) begin
                errors++;
                $display("%s: m_req transfers came %0d cycles apart, expected %0d to %0d",
                         name, d, min_d, max_d);
            end
        end
    endtask

    task automatic end_test(input string name, input int err_start);
        tests_run++;
        if (errors == err_start) begin
            tests_passed++;
            $display("%s: PASS", name);
        end else begin
            $display("%s: FAIL with %0d errors", name, errors - err_start);
        end
    endtask

    task automatic check_reset_state();
        int e;
        e = errors;
        @(negedge aclk);
        compare_bit("reset_state", 1'b0, s_req_ready);
        compare_bit("reset_state", 1'b0, s_ack_ready);
        compare_bit("reset_state", 1'b0, m_req_valid);
        compare_bit("reset_state", 1'b0, m_ack_valid);
        end_test("reset_state", e);
    endtask

    task automatic fill_write_window();
        rdma_flow_pkg::req_t r;
        int e;
        e = errors;
        set_ready_mode(2'd2);
        for (int i = 0; i < 4; i++) begin
            make_req(rdma_flow_pkg::OP_WR_REQ, 4'h1, 4'h2, r);
            send_req("fill_window", r);
        end
        wait_outputs("fill_window");
        set_ready_mode(2'd1);
        end_test("fill_window", e);
    endtask

    task automatic block_fifth_request();
        rdma_flow_pkg::req_t r;
        rdma_flow_pkg::ack_in_t a;
        int e;
        e = errors;
        make_req(rdma_flow_pkg::OP_WR_REQ, 4'h1, 4'h2, r);
        start_req(r);
        expect_blocked("fifth_request", 50);
        make_ack(rdma_flow_pkg::OP_ACK, 4'h1, 4'h2, 2'd0, 1'b0, a);
        send_ack("fifth_request", a);
        finish_req("fifth_request");
        wait_outputs("fifth_request");
        end_test("fifth_request", e);
    endtask

    task automatic split_read_write();
        rdma_flow_pkg::req_t r;
        rdma_flow_pkg::ack_in_t a;
        int e;
        e = errors;
        for (int i = 0; i < 4; i++) begin
            make_req(rdma_flow_pkg::OP_WR_REQ, 4'h2, 4'h7, r);
            send_req("read_write_split", r);
        end
        // Read key has its own window
        make_req(rdma_flow_pkg::OP_RD_REQ, 4'h2, 4'h7, r);
        send_req("read_write_split", r);
        make_req(rdma_flow_pkg::OP_WR_REQ, 4'h2, 4'h7, r);
        start_req(r);
        expect_blocked("read_write_split", 20);
        make_ack(rdma_flow_pkg::OP_RD_RESP, 4'h2, 4'h7, 2'd0, 1'b0, a);
        send_ack("read_write_split", a);
        expect_blocked("read_write_split", 50);
        make_ack(rdma_flow_pkg::OP_ACK, 4'h2, 4'h7, 2'd0, 1'b0, a);
        send_ack("read_write_split", a);
        finish_req("read_write_split");
        // Read window is empty again after the response
        for (int i = 0; i < 4; i++) begin
            make_req(rdma_flow_pkg::OP_RD_REQ, 4'h2, 4'h7, r);
            send_req("read_write_split", r);
        end
        wait_outputs("read_write_split");
        end_test("read_write_split", e);
    endtask

    task automatic last_ack_filter();
        rdma_flow_pkg::req_t r;
        rdma_flow_pkg::ack_in_t a;
        int e;
        e = errors;
        for (int i = 0; i < 4; i++) begin
            make_req(rdma_flow_pkg::OP_WR_REQ, 4'h3, 4'h5, r);
            send_req("last_ack", r);
        end
        // A CE code without last is not a congestion mark
        make_ack(rdma_flow_pkg::OP_ACK, 4'h3, 4'h5, 2'd3, 1'b0, a);
        send_ack("last_ack", a);
        make_ack(rdma_flow_pkg::OP_ACK, 4'h3, 4'h5, 2'd1, 1'b1, a);
        send_ack("last_ack", a);
        make_ack(rdma_flow_pkg::OP_ACK, 4'h3, 4'h5, 2'd2, 1'b0, a);
        send_ack("last_ack", a);
        make_ack(rdma_flow_pkg::OP_ACK, 4'h3, 4'h5, 2'd0, 1'b1, a);
        send_ack("last_ack", a);
        wait_outputs("last_ack");
        for (int i = 0; i < 4; i++) begin
            make_req(rdma_flow_pkg::OP_WR_REQ, 4'h3, 4'h5, r);
            send_req("last_ack", r);
        end
        wait_outputs("last_ack");
        end_test("last_ack", e);
    endtask

    task automatic ecn_pacing();
        rdma_flow_pkg::req_t r;
        rdma_flow_pkg::ack_in_t a;
        int e;
        e = errors;
        set_ready_mode(2'd0);
        for (int i = 0; i < 4; i++) begin
            make_req(rdma_flow_pkg::OP_WR_REQ, 4'h0, 4'h9, r);
            send_req("ecn_pacing", r);
        end
        set_ready_mode(2'd1);
        check_spacing("ecn_pacing", 1, 1);
        wait_outputs("ecn_pacing");
        // Two marks take the gap from 0 to 1 to 2
        make_ack(rdma_flow_pkg::OP_ACK, 4'h0, 4'h9, 2'd3, 1'b1, a);
        send_ack("ecn_pacing", a);
        send_ack("ecn_pacing", a);
        set_ready_mode(2'd0);
        for (int i = 0; i < 4; i++) begin
            make_req(rdma_flow_pkg::OP_WR_REQ, 4'h0, 4'ha, r);
            send_req("ecn_pacing", r);
        end
        set_ready_mode(2'd1);
        check_spacing("ecn_pacing", 3, 3);
        wait_outputs("ecn_pacing");
        end_test("ecn_pacing", e);
    endtask

    initial begin
        aresetn = 1'b0;
        s_req_valid = 1'b0;
        s_req_data = '0;
        s_ack_valid = 1'b0;
        s_ack_data = '0;
        m_req_ready = 1'b0;
        m_ack_ready = 1'b0;
        ready_mode = 2'd1;
        len_lfsr = LFSR_SEED;
        rdy_lfsr = LFSR_SEED;
        repeat (2) @(posedge aclk);
        #1;
        aresetn = 1'b1;
        m_ack_ready = 1'b1;

        check_reset_state();
        fill_write_window();
        block_fifth_request();
        split_read_write();
        last_ack_filter();
        ecn_pacing();

        $display("tests run %0d, passed %0d, errors %0d", tests_run, tests_passed, errors);
        if (errors == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

// File: hw/rdma_flow.sv
`timescale 1ns/1ns

module rdma_flow (
    input  logic                    aclk,
    input  logic                    aresetn,

    input  logic                    s_req_valid,
    output logic                    s_req_ready,
    input  rdma_flow_pkg::req_t     s_req_data,

    output logic                    m_req_valid,
    input  logic                    m_req_ready,
    output rdma_flow_pkg::req_t     m_req_data,

    input  logic                    s_ack_valid,
    output logic                    s_ack_ready,
    input  rdma_flow_pkg::ack_in_t  s_ack_data,

    output logic                    m_ack_valid,
    input  logic                    m_ack_ready,
    output rdma_flow_pkg::ack_t     m_ack_data
);

    logic                      fwd_valid;
    logic                      fwd_ready;
    rdma_flow_pkg::req_t       fwd_data;

    logic                      cq_valid;
    logic                      cq_ready;
    rdma_flow_pkg::ack_t       cq_data;

    logic                      ecn_mark;

    logic                      tbl_we;
    rdma_flow_pkg::key_t       tbl_addr;
    rdma_flow_pkg::tbl_entry_t tbl_wdata;
    rdma_flow_pkg::tbl_entry_t tbl_rdata;

    flow_sequencer inst_seq (
        .aclk        (aclk),
        .aresetn     (aresetn),
        .s_req_valid (s_req_valid),
        .s_req_ready (s_req_ready),
        .s_req_data  (s_req_data),
        .s_ack_valid (s_ack_valid),
        .s_ack_ready (s_ack_ready),
        .s_ack_data  (s_ack_data),
        .fwd_valid   (fwd_valid),
        .fwd_ready   (fwd_ready),
        .fwd_data    (fwd_data),
        .cq_valid    (cq_valid),
        .cq_ready    (cq_ready),
        .cq_data     (cq_data),
        .ecn_mark    (ecn_mark),
        .tbl_we      (tbl_we),
        .tbl_addr    (tbl_addr),
        .tbl_wdata   (tbl_wdata),
        .tbl_rdata   (tbl_rdata)
    );

    // Pointer table
    ssn_table inst_table (
        .aclk  (aclk),
        .we    (tbl_we),
        .addr  (tbl_addr),
        .wdata (tbl_wdata),
        .rdata (tbl_rdata)
    );

    ack_queue inst_cq (
        .aclk    (aclk),
        .aresetn (aresetn),
        .s_valid (cq_valid),
        .s_ready (cq_ready),
        .s_data  (cq_data),
        .m_valid (m_ack_valid),
        .m_ready (m_ack_ready),
        .m_data  (m_ack_data)
    );

    cc_queue inst_cc (
        .aclk     (aclk),
        .aresetn  (aresetn),
        .ecn_mark (ecn_mark),
        .s_valid  (fwd_valid),
        .s_ready  (fwd_ready),
        .s_data   (fwd_data),
        .m_valid  (m_req_valid),
        .m_ready  (m_req_ready),
        .m_data   (m_req_data)
    );

endmodule

// File: hw/cc_queue.sv
`timescale 1ns/1ns

module cc_queue (
    input  logic                 aclk,
    input  logic                 aresetn,

    input  logic                 ecn_mark,

    input  logic                 s_valid,
    output logic                 s_ready,
    input  rdma_flow_pkg::req_t  s_data,

    output logic                 m_valid,
    input  logic                 m_ready,
    output rdma_flow_pkg::req_t  m_data
);

    rdma_flow_pkg::req_t mem [rdma_flow_pkg::REQ_QDEPTH];

    logic [$clog2(rdma_flow_pkg::REQ_QDEPTH)-1:0] wr_ptr;
    logic [$clog2(rdma_flow_pkg::REQ_QDEPTH)-1:0] rd_ptr;
    logic [$clog2(rdma_flow_pkg::REQ_QDEPTH):0]   count;

    rdma_flow_pkg::gap_t gap;
    rdma_flow_pkg::gap_t gap_cnt;

    logic [$clog2(rdma_flow_pkg::RECOVER_CYCLES)-1:0] recover_cnt;

    logic push;
    logic pop;

    assign s_ready = count != rdma_flow_pkg::REQ_QDEPTH;
    // Held low while the pacing gap runs
    assign m_valid = (count != 0) && (gap_cnt == '0);
    assign m_data = mem[rd_ptr];

    assign push = s_valid && s_ready;
    assign pop = m_valid && m_ready;

    always_ff @(posedge aclk) begin
        if (!aresetn) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count <= '0;
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            if (push && !pop) begin
                count <= count + 1'b1;
            end else if (pop && !push) begin
                count <= count - 1'b1;
            end
        end
    end

    always_ff @(posedge aclk) begin
        if (push) begin
            mem[wr_ptr] <= s_data;
        end
    end

    // Inter-request spacing
    always_ff @(posedge aclk) begin
        if (!aresetn) begin
            gap_cnt <= '0;
        end else if (pop) begin
            gap_cnt <= gap;
        end else if (gap_cnt != '0) begin
            gap_cnt <= gap_cnt - 1'b1;
        end
    end

    // Doubles on each mark, halves after a quiet period
    always_ff @(posedge aclk) begin
        if (!aresetn) begin
            gap <= '0;
            recover_cnt <= '0;
        end else if (ecn_mark) begin
            recover_cnt <= '0;
            if (gap == '0) begin
                gap <= rdma_flow_pkg::gap_t'(1);
            end else if (gap >= rdma_flow_pkg::gap_t'(rdma_flow_pkg::MAX_GAP / 2)) begin
                gap <= rdma_flow_pkg::gap_t'(rdma_flow_pkg::MAX_GAP);
            end else begin
                gap <= gap << 1;
            end
        end else if (recover_cnt == rdma_flow_pkg::RECOVER_CYCLES - 1) begin
            recover_cnt <= '0;
            gap <= gap >> 1;
        end else begin
            recover_cnt <= recover_cnt + 1'b1;
        end
    end

endmodule

// File: hw/ack_queue.sv
`timescale 1ns/1ns

module ack_queue (
    input  logic                 aclk,
    input  logic                 aresetn,

    input  logic                 s_valid,
    output logic                 s_ready,
    input  rdma_flow_pkg::ack_t  s_data,

    output logic                 m_valid,
    input  logic                 m_ready,
    output rdma_flow_pkg::ack_t  m_data
);

    rdma_flow_pkg::ack_t mem [rdma_flow_pkg::ACK_QDEPTH];

    logic [$clog2(rdma_flow_pkg::ACK_QDEPTH)-1:0] wr_ptr;
    logic [$clog2(rdma_flow_pkg::ACK_QDEPTH)-1:0] rd_ptr;
    logic [$clog2(rdma_flow_pkg::ACK_QDEPTH):0]   count;

    logic push;
    logic pop;

    assign s_ready = count != rdma_flow_pkg::ACK_QDEPTH;
    assign m_valid = count != 0;
    assign m_data = mem[rd_ptr];

    assign push = s_valid && s_ready;
    assign pop = m_valid && m_ready;

    always_ff @(posedge aclk) begin
        if (!aresetn) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count <= '0;
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            if (push && !pop) begin
                count <= count + 1'b1;
            end else if (pop && !push) begin
                count <= count - 1'b1;
            end
        end
    end

    always_ff @(posedge aclk) begin
        if (push) begin
            mem[wr_ptr] <= s_data;
        end
    end

endmodule

// File: hw/flow_sequencer.sv
`timescale 1ns/1ns

module flow_sequencer (
    input  logic                       aclk,
    input  logic                       aresetn,

    input  logic                       s_req_valid,
    output logic                       s_req_ready,
    input  rdma_flow_pkg::req_t        s_req_data,

    input  logic                       s_ack_valid,
    output logic                       s_ack_ready,
    input  rdma_flow_pkg::ack_in_t     s_ack_data,

    output logic                       fwd_valid,
    input  logic                       fwd_ready,
    output rdma_flow_pkg::req_t        fwd_data,

    output logic                       cq_valid,
    input  logic                       cq_ready,
    output rdma_flow_pkg::ack_t        cq_data,

    output logic                       ecn_mark,

    output logic                       tbl_we,
    output rdma_flow_pkg::key_t        tbl_addr,
    output rdma_flow_pkg::tbl_entry_t  tbl_wdata,
    input  rdma_flow_pkg::tbl_entry_t  tbl_rdata
);

    typedef enum logic [2:0] {
        ST_IDLE,
        ST_ACK_WAIT,
        ST_REQ_WAIT,
        ST_ACK_LUP,
        ST_REQ_LUP
    } state_t;

    state_t state_q;
    state_t state_d;

    rdma_flow_pkg::key_t addr_q;
    rdma_flow_pkg::key_t ack_key;
    rdma_flow_pkg::key_t req_key;
    rdma_flow_pkg::ost_t tail_inc;

    logic ack_is_ce;

    // Read flag, low vfid bits, pid
    assign ack_key = {s_ack_data.ack.opcode == rdma_flow_pkg::OP_RD_RESP,
                      s_ack_data.ack.vfid[rdma_flow_pkg::N_REGIONS_BITS-1:0],
                      s_ack_data.ack.pid};
    assign req_key = {s_req_data.opcode == rdma_flow_pkg::OP_RD_REQ,
                      s_req_data.vfid[rdma_flow_pkg::N_REGIONS_BITS-1:0],
                      s_req_data.pid};

    assign tail_inc = tbl_rdata.tail + rdma_flow_pkg::ost_t'(1);
    assign ack_is_ce = s_ack_data.ack.ecn == 2'(rdma_flow_pkg::ECN_CE);

    always_ff @(posedge aclk) begin
        if (!aresetn) begin
            state_q <= ST_IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    // Key is captured on the idle cycle and held through the lookup
    always_ff @(posedge aclk) begin
        if (state_q == ST_IDLE) begin
            addr_q <= tbl_addr;
        end
    end

    always_comb begin
        state_d = state_q;

        s_ack_ready = 1'b0;
        cq_valid = 1'b0;
        cq_data = s_ack_data.ack;
        ecn_mark = 1'b0;

        s_req_ready = 1'b0;
        fwd_valid = 1'b0;
        fwd_data = s_req_data;
        fwd_data.offs = tbl_rdata.head;

        tbl_we = 1'b0;
        tbl_addr = addr_q;
        tbl_wdata = tbl_rdata;

        case (state_q)
            ST_IDLE: begin
                // Acks win over requests
                if (s_ack_valid) begin
                    tbl_addr = ack_key;
                    if (cq_ready) begin
                        s_ack_ready = 1'b1;
                        cq_valid = s_ack_data.last;
                        ecn_mark = s_ack_data.last && ack_is_ce;
                        state_d = ST_ACK_WAIT;
                    end
                end else if (s_req_valid && fwd_ready) begin
                    tbl_addr = req_key;
                    state_d = ST_REQ_WAIT;
                end
            end

            ST_ACK_WAIT: begin
                state_d = ST_ACK_LUP;
            end

            ST_REQ_WAIT: begin
                state_d = ST_REQ_LUP;
            end

            ST_ACK_LUP: begin
                tbl_we = 1'b1;
                tbl_wdata.tail = tail_inc;
                tbl_wdata.issued = (tbl_rdata.head == tail_inc) ? 1'b0 : tbl_rdata.issued;
                state_d = ST_IDLE;
            end

            ST_REQ_LUP: begin
                // Window full when issued and head caught up with tail
                if (!tbl_rdata.issued || (tbl_rdata.head != tbl_rdata.tail)) begin
                    s_req_ready = 1'b1;
                    fwd_valid = 1'b1;
                    tbl_we = 1'b1;
                    tbl_wdata.head = tbl_rdata.head + rdma_flow_pkg::ost_t'(1);
                    tbl_wdata.issued = 1'b1;
                end
                state_d = ST_IDLE;
            end

            default: begin
                state_d = ST_IDLE;
            end
        endcase
    end

endmodule

// File: hw/ssn_table.sv
`timescale 1ns/1ns

module ssn_table (
    input  logic                     aclk,
    input  logic                     we,
    input  rdma_flow_pkg::key_t      addr,
    input  rdma_flow_pkg::tbl_entry_t wdata,
    output rdma_flow_pkg::tbl_entry_t rdata
);

    rdma_flow_pkg::tbl_entry_t mem [2**rdma_flow_pkg::KEY_BITS];

    // Read-first, one cycle of read latency
    always_ff @(posedge aclk) begin
        if (we) begin
            mem[addr] <= wdata;
        end
        rdata <= mem[addr];
    end

endmodule

// File: hw/rdma_flow_pkg.sv
package rdma_flow_pkg;

    // Key geometry
    localparam int N_REGIONS_BITS = 2;
    localparam int PID_BITS = 4;
    localparam int KEY_BITS = 1 + N_REGIONS_BITS + PID_BITS;

    // Outstanding window per key
    localparam int RDMA_N_OST = 4;
    localparam int OST_BITS = $clog2(RDMA_N_OST);

    // Queue depths
    localparam int ACK_QDEPTH = 4;
    localparam int REQ_QDEPTH = 4;

    // Congestion pacing
    localparam int MAX_GAP = 16;
    localparam int RECOVER_CYCLES = 64;
    localparam int ECN_CE = 3;

    typedef logic [4:0] opcode_t;
    typedef logic [3:0] vfid_t;
    typedef logic [PID_BITS-1:0] pid_t;
    typedef logic [KEY_BITS-1:0] key_t;
    typedef logic [OST_BITS-1:0] ost_t;
    typedef logic [4:0] gap_t;

    localparam opcode_t OP_RD_REQ = 5'h00;
    localparam opcode_t OP_WR_REQ = 5'h01;
    localparam opcode_t OP_RD_RESP = 5'h02;
    localparam opcode_t OP_ACK = 5'h03;

    // Pointer table entry, head counts issued and tail counts acked
    typedef struct packed {
        logic issued;
        ost_t head;
        ost_t tail;
    } tbl_entry_t;

    typedef struct packed {
        opcode_t     opcode;
        vfid_t       vfid;
        pid_t        pid;
        ost_t        offs;
        logic [15:0] len;
    } req_t;

    typedef struct packed {
        opcode_t    opcode;
        vfid_t      vfid;
        pid_t       pid;
        logic [1:0] ecn;
    } ack_t;

    typedef struct packed {
        ack_t ack;
        logic last;
    } ack_in_t;

endpackage
